/* logic/usb_tx_pkg.sv */
// Shared types and constants for the USB full-speed packet transmitter.
// Modules reach these by scoped names from usb_tx_pkg.

package usb_tx_pkg;

  // PID nibble as sent on the wire, group in the low bits
  typedef struct packed {
    logic [1:0] code;
    logic [1:0] group;
  } pid_fields_t;

  // Raw view builds the PID byte, field view picks the packet type
  typedef union packed {
    logic [3:0]  raw;
    pid_fields_t fields;
  } pid_u;

  localparam logic [1:0] PidGroupData = 2'd3;

  // Line constants
  localparam logic [7:0] SyncByte   = 8'h80;
  localparam logic [7:0] EopMask    = 8'b0000_0111;
  localparam int         StuffLimit = 6;

  // USB CRC16 over the data payload
  localparam logic [15:0] Crc16Poly = 16'h8005;
  localparam logic [15:0] Crc16Init = 16'hFFFF;

  // What the sequencer places into the serializer shift registers
  typedef enum logic [1:0] {LoadData, LoadEop, LoadIdle} load_kind_e;

  localparam int DefaultClksPerBit = 4;

endpackage

/* logic/usb_bit_timer.sv */
// Bit timer for the transmitter.
// Emits a bit strobe every ClksPerBit clocks and a byte strobe after
// each eighth bit that was not a stuffing slot.

module usb_bit_timer #(
  parameter int ClksPerBit = usb_tx_pkg::DefaultClksPerBit
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic link_reset_i,
  input  logic restart_i,
  input  logic stuff_hold_i,
  output logic bit_strobe_o,
  output logic byte_strobe_o
);

  localparam int CntW = $clog2(ClksPerBit);

  logic [CntW-1:0] clk_cnt_q;
  logic [2:0]      bit_cnt_q;
  logic            byte_strobe_q;
  logic            bit_counted;

  assign bit_strobe_o  = (clk_cnt_q == CntW'(ClksPerBit - 1));
  assign bit_counted   = bit_strobe_o && !stuff_hold_i && !restart_i;
  assign byte_strobe_o = byte_strobe_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clk_cnt_q     <= '0;
      bit_cnt_q     <= '0;
      byte_strobe_q <= 1'b0;
    end else if (link_reset_i) begin
      clk_cnt_q     <= '0;
      bit_cnt_q     <= '0;
      byte_strobe_q <= 1'b0;
    end else begin
      if (restart_i || bit_strobe_o) begin
        clk_cnt_q <= '0;
      end else begin
        clk_cnt_q <= clk_cnt_q + CntW'(1);
      end
      // First byte boundary one bit time after a restart
      if (restart_i) begin
        bit_cnt_q <= 3'd0;
      end else if (bit_counted) begin
        bit_cnt_q <= bit_cnt_q + 3'd1;
      end
      byte_strobe_q <= bit_counted && (bit_cnt_q == 3'd0);
    end
  end

endmodule

/* logic/usb_tx_sequencer.sv */
// Packet sequencer of the transmitter.
// On every byte strobe it picks the next byte for the serializer: SYNC,
// PID, payload pulled from the source, the CRC16 halves and the EOP.

module usb_tx_sequencer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   link_reset_i,
  input  logic                   pkt_start_i,
  input  logic [3:0]             pid_i,
  input  logic                   byte_strobe_i,
  input  logic                   tx_data_avail_i,
  input  logic [7:0]             tx_data_i,
  input  logic [15:0]            crc_i,
  output logic                   tx_data_get_o,
  output logic                   load_o,
  output logic [7:0]             load_byte_o,
  output usb_tx_pkg::load_kind_e load_kind_o,
  output logic                   payload_active_o
);

  // State names the byte that goes out at the next byte strobe
  typedef enum logic [2:0] {Idle, Sync, Pid, Data, CrcHigh, CrcLow, Eop} state_e;

  state_e           state_q, state_d;
  state_e           slot;
  usb_tx_pkg::pid_u pid_q;
  logic             get_q, get_d;
  logic             payload_q, payload_d;

  // CRC goes out MSB first, so each half is mirrored before the LSB-first shift
  function automatic logic [7:0] reverse_byte(input logic [7:0] b);
    logic [7:0] r;
    for (int i = 0; i < 8; i++) begin
      r[i] = b[7-i];
    end
    return r;
  endfunction

  always_ff @(posedge clk_i) begin
    if (state_q == Idle && pkt_start_i) begin
      pid_q.raw <= pid_i;
    end
  end

  // A data slot with nothing available becomes the first CRC slot
  assign slot = (state_q == Data && !tx_data_avail_i) ? CrcHigh : state_q;

  always_comb begin
    state_d     = state_q;
    get_d       = 1'b0;
    payload_d   = payload_q;
    load_o      = 1'b0;
    load_byte_o = 8'h00;
    load_kind_o = usb_tx_pkg::LoadData;

    unique case (slot)
      Idle: begin
        // Clear the shifters so the new packet starts from a quiet line
        if (pkt_start_i) begin
          state_d     = Sync;
          load_o      = 1'b1;
          load_kind_o = usb_tx_pkg::LoadIdle;
        end
      end
      Sync: begin
        if (byte_strobe_i) begin
          state_d     = Pid;
          load_o      = 1'b1;
          load_byte_o = usb_tx_pkg::SyncByte;
        end
      end
      Pid: begin
        if (byte_strobe_i) begin
          load_o      = 1'b1;
          load_byte_o = {~pid_q.raw, pid_q.raw};
          if (pid_q.fields.group == usb_tx_pkg::PidGroupData) begin
            state_d = Data;
          end else begin
            state_d = Eop;
          end
        end
      end
      Data: begin
        if (byte_strobe_i) begin
          load_o      = 1'b1;
          load_byte_o = tx_data_i;
          get_d       = 1'b1;
          payload_d   = 1'b1;
        end
      end
      CrcHigh: begin
        if (byte_strobe_i) begin
          state_d     = CrcLow;
          load_o      = 1'b1;
          load_byte_o = ~reverse_byte(crc_i[15:8]);
          payload_d   = 1'b0;
        end
      end
      CrcLow: begin
        if (byte_strobe_i) begin
          state_d     = Eop;
          load_o      = 1'b1;
          load_byte_o = ~reverse_byte(crc_i[7:0]);
        end
      end
      Eop: begin
        if (byte_strobe_i) begin
          state_d     = Idle;
          load_o      = 1'b1;
          load_kind_o = usb_tx_pkg::LoadEop;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= Idle;
      get_q     <= 1'b0;
      payload_q <= 1'b0;
    end else if (link_reset_i) begin
      state_q   <= Idle;
      get_q     <= 1'b0;
      payload_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      get_q     <= get_d;
      payload_q <= payload_d;
    end
  end

  assign tx_data_get_o    = get_q;
  assign payload_active_o = payload_q;

endmodule

/* logic/usb_tx_serializer.sv */
// Serializer of the transmitter.
// Shifts data, output enable and SE0 out LSB first on each bit strobe and
// inserts a zero after a run of ones, holding the shift for that slot.

module usb_tx_serializer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   link_reset_i,
  input  logic                   pkt_start_i,
  input  logic                   bit_strobe_i,
  input  logic                   load_i,
  input  logic [7:0]             load_byte_i,
  input  usb_tx_pkg::load_kind_e load_kind_i,
  output logic                   serial_data_o,
  output logic                   serial_oe_o,
  output logic                   serial_se0_o,
  output logic                   stuffed_o,
  output logic                   stuff_hold_o
);

  localparam int HistW = usb_tx_pkg::StuffLimit - 1;

  logic [7:0]       data_q, oe_q, se0_q;
  logic [HistW-1:0] hist_q;
  logic             stuffed_q;
  logic             stuff;

  assign serial_data_o = data_q[0];
  assign serial_oe_o   = oe_q[0];
  assign serial_se0_o  = se0_q[0];

  // Bit on the line now plus the previous ones, newest at the top
  assign stuff        = &{data_q[0], hist_q};
  assign stuff_hold_o = stuff;
  assign stuffed_o    = stuffed_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_q    <= '0;
      oe_q      <= '0;
      se0_q     <= '0;
      hist_q    <= '0;
      stuffed_q <= 1'b0;
    end else if (link_reset_i) begin
      data_q    <= '0;
      oe_q      <= '0;
      se0_q     <= '0;
      hist_q    <= '0;
      stuffed_q <= 1'b0;
    end else begin
      ////////////////////////////////
      // Shift registers
      ////////////////////////////////
      if (load_i) begin
        data_q <= load_byte_i;
        unique case (load_kind_i)
          usb_tx_pkg::LoadData: begin
            oe_q  <= 8'hFF;
            se0_q <= 8'h00;
          end
          usb_tx_pkg::LoadEop: begin
            oe_q  <= usb_tx_pkg::EopMask;
            se0_q <= usb_tx_pkg::EopMask;
          end
          default: begin
            oe_q  <= 8'h00;
            se0_q <= 8'h00;
          end
        endcase
      end else if (bit_strobe_i) begin
        if (stuff) begin
          // Sent bit is replaced by the stuffed zero for the next slot
          data_q[0] <= 1'b0;
        end else begin
          data_q <= data_q >> 1;
          oe_q   <= oe_q >> 1;
          se0_q  <= se0_q >> 1;
        end
      end

      ////////////////////////////////
      // Run history
      ////////////////////////////////
      if (pkt_start_i) begin
        hist_q    <= '0;
        stuffed_q <= 1'b0;
      end else if (bit_strobe_i) begin
        hist_q    <= {data_q[0], hist_q[HistW-1:1]};
        // Marks the slot that carries the stuffed zero
        stuffed_q <= stuff;
      end
    end
  end

endmodule

/* logic/usb_crc16.sv */
// CRC16 generator for the data payload.
// Fed one bit per bit strobe as it leaves the serializer, skipping
// stuffed zeros and anything outside the payload.

module usb_crc16 (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        link_reset_i,
  input  logic        pkt_start_i,
  input  logic        bit_strobe_i,
  input  logic        payload_active_i,
  input  logic        serial_data_i,
  input  logic        stuffed_i,
  output logic [15:0] crc_o
);

  logic [15:0] crc_q;
  logic        feedback;

  assign feedback = serial_data_i ^ crc_q[15];
  assign crc_o    = crc_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      crc_q <= usb_tx_pkg::Crc16Init;
    end else if (link_reset_i || pkt_start_i) begin
      crc_q <= usb_tx_pkg::Crc16Init;
    end else if (bit_strobe_i && payload_active_i && !stuffed_i) begin
      crc_q <= {crc_q[14:0], 1'b0} ^ ({16{feedback}} & usb_tx_pkg::Crc16Poly);
    end
  end

endmodule

/* logic/usb_line_driver.sv */
// Line driver of the transmitter.
// NRZI-encodes the serial stream, forms the EOP, applies the D+/D- pin
// flip and drives registered dp, dn and oe.

module usb_line_driver (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic link_reset_i,
  input  logic cfg_pinflip_i,
  input  logic pkt_start_i,
  input  logic bit_strobe_i,
  input  logic serial_data_i,
  input  logic serial_oe_i,
  input  logic serial_se0_i,
  output logic usb_dp_o,
  output logic usb_dn_o,
  output logic usb_oe_o,
  output logic pkt_end_o
);

  typedef enum logic [1:0] {OsIdle, OsWaitByte, OsTransmit} out_state_e;

  out_state_e state_q, state_d;
  logic       d_q, d_d;
  logic       se0_q, se0_d;
  logic       oe_q, oe_d;
  logic [2:0] eop_q, eop_d;
  logic       end_q, end_d;
  logic       dp_q, dp_d;
  logic       dn_q, dn_d;
  logic       tx_en;

  always_comb begin
    state_d = state_q;
    d_d     = d_q;
    se0_d   = se0_q;
    oe_d    = oe_q;
    eop_d   = eop_q;
    end_d   = 1'b0;
    tx_en   = 1'b0;

    unique case (state_q)
      OsIdle: begin
        if (pkt_start_i) begin
          state_d = OsWaitByte;
        end
      end
      OsWaitByte: begin
        // SYNC loaded, its first bit may already be due
        if (serial_oe_i) begin
          tx_en   = 1'b1;
          state_d = OsTransmit;
        end
      end
      OsTransmit: begin
        tx_en = 1'b1;
        if (bit_strobe_i && !serial_oe_i) begin
          state_d = OsIdle;
        end
      end
      default: state_d = OsIdle;
    endcase

    if (pkt_start_i) begin
      d_d   = 1'b1;
      eop_d = 3'b100;
    end else if (bit_strobe_i && tx_en) begin
      oe_d = serial_oe_i;
      if (serial_se0_i) begin
        // Two SE0 bits, then J
        eop_d = eop_q >> 1;
        if (eop_q[0]) begin
          d_d   = 1'b1;
          se0_d = 1'b0;
          end_d = 1'b1;
        end else begin
          se0_d = 1'b1;
        end
      end else if (!serial_data_i) begin
        d_d = ~d_q;
      end
      // Idle line sits at J
      if (!oe_d) begin
        d_d = 1'b1;
      end
    end

    if (link_reset_i) begin
      state_d = OsIdle;
      d_d     = 1'b1;
      se0_d   = 1'b0;
      oe_d    = 1'b0;
      eop_d   = 3'b000;
      end_d   = 1'b0;
    end

    dp_d = (cfg_pinflip_i ? ~d_d :  d_d) & ~se0_d;
    dn_d = (cfg_pinflip_i ?  d_d : ~d_d) & ~se0_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= OsIdle;
      d_q     <= 1'b1;
      se0_q   <= 1'b0;
      oe_q    <= 1'b0;
      eop_q   <= 3'b000;
      end_q   <= 1'b0;
      dp_q    <= 1'b1;
      dn_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      d_q     <= d_d;
      se0_q   <= se0_d;
      oe_q    <= oe_d;
      eop_q   <= eop_d;
      end_q   <= end_d;
      dp_q    <= dp_d;
      dn_q    <= dn_d;
    end
  end

  assign usb_dp_o  = dp_q;
  assign usb_dn_o  = dn_q;
  assign usb_oe_o  = oe_q;
  assign pkt_end_o = end_q;

endmodule

/* logic/usb_fs_tx_top.sv */
// Top level of the USB full-speed packet transmitter.
// Connects bit timer, sequencer, serializer, CRC and line driver.

module usb_fs_tx_top #(
  parameter int ClksPerBit = usb_tx_pkg::DefaultClksPerBit
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       link_reset_i,
  input  logic       cfg_pinflip_i,
  input  logic       pkt_start_i,
  input  logic [3:0] pid_i,
  input  logic       tx_data_avail_i,
  input  logic [7:0] tx_data_i,
  output logic       tx_data_get_o,
  output logic       pkt_end_o,
  output logic       usb_dp_o,
  output logic       usb_dn_o,
  output logic       usb_oe_o
);

  logic                   bit_strobe, byte_strobe, stuff_hold;
  logic                   load, payload_active;
  logic [7:0]             load_byte;
  usb_tx_pkg::load_kind_e load_kind;
  logic                   serial_data, serial_oe, serial_se0, stuffed;
  logic [15:0]            crc_q;

  usb_bit_timer #(
    .ClksPerBit(ClksPerBit)
  ) u_bit_timer (
    .clk_i, .rst_ni, .link_reset_i,
    .restart_i     (pkt_start_i),
    .stuff_hold_i  (stuff_hold),
    .bit_strobe_o  (bit_strobe),
    .byte_strobe_o (byte_strobe)
  );

  usb_tx_sequencer u_sequencer (
    .clk_i, .rst_ni, .link_reset_i, .pkt_start_i, .pid_i,
    .byte_strobe_i    (byte_strobe),
    .tx_data_avail_i, .tx_data_i,
    .crc_i            (crc_q),
    .tx_data_get_o,
    .load_o           (load),
    .load_byte_o      (load_byte),
    .load_kind_o      (load_kind),
    .payload_active_o (payload_active)
  );

  usb_tx_serializer u_serializer (
    .clk_i, .rst_ni, .link_reset_i, .pkt_start_i,
    .bit_strobe_i  (bit_strobe),
    .load_i        (load),
    .load_byte_i   (load_byte),
    .load_kind_i   (load_kind),
    .serial_data_o (serial_data),
    .serial_oe_o   (serial_oe),
    .serial_se0_o  (serial_se0),
    .stuffed_o     (stuffed),
    .stuff_hold_o  (stuff_hold)
  );

  usb_crc16 u_crc16 (
    .clk_i, .rst_ni, .link_reset_i, .pkt_start_i,
    .bit_strobe_i     (bit_strobe),
    .payload_active_i (payload_active),
    .serial_data_i    (serial_data),
    .stuffed_i        (stuffed),
    .crc_o            (crc_q)
  );

  usb_line_driver u_line_driver (
    .clk_i, .rst_ni, .link_reset_i, .cfg_pinflip_i, .pkt_start_i,
    .bit_strobe_i  (bit_strobe),
    .serial_data_i (serial_data),
    .serial_oe_i   (serial_oe),
    .serial_se0_i  (serial_se0),
    .usb_dp_o, .usb_dn_o, .usb_oe_o, .pkt_end_o
  );

endmodule

/* dv/usb_tx_model.svh */
// Reference model of the transmitter's line output.
// Included inside the testbench module; build_expected() fills exp_line_q
// with the {dp, dn} state expected in each bit time of one packet.

`ifndef USB_TX_MODEL_SVH
`define USB_TX_MODEL_SVH

logic [1:0] exp_line_q[$];
bit         raw_bits_q[$];
bit         model_crc_stuffed;

// J for level 1, K for level 0, as seen on {dp, dn}
function automatic logic [1:0] line_level(input bit level, input bit flip);
  if (flip) begin
    return {~level, level};
  end
  return {level, ~level};
endfunction

function automatic void push_byte(input logic [7:0] value);
  for (int i = 0; i < 8; i++) begin
    raw_bits_q.push_back(value[i]);
  end
endfunction

function automatic void build_expected(input logic [3:0] pid, input bit flip);
  logic [15:0] crc;
  bit          fb;
  bit          level;
  int          run;
  int          crc_start;
  raw_bits_q.delete();
  exp_line_q.delete();
  model_crc_stuffed = 1'b0;
  crc = usb_tx_pkg::Crc16Init;
  push_byte(usb_tx_pkg::SyncByte);
  push_byte({~pid, pid});
  crc_start = raw_bits_q.size();
  if (pid[1:0] == usb_tx_pkg::PidGroupData) begin
    for (int n = 0; n < payload_len; n++) begin
      for (int i = 0; i < 8; i++) begin
        raw_bits_q.push_back(payload_mem[n][i]);
        fb  = payload_mem[n][i] ^ crc[15];
        crc = {crc[14:0], 1'b0};
        if (fb) begin
          crc = crc ^ usb_tx_pkg::Crc16Poly;
        end
      end
    end
    crc_start = raw_bits_q.size();
    // Inverted remainder goes out high bit first
    for (int i = 15; i >= 0; i--) begin
      raw_bits_q.push_back(~crc[i]);
    end
  end

  // Stuffing and NRZI in one pass, the line starts at J
  run   = 0;
  level = 1'b1;
  for (int k = 0; k < raw_bits_q.size(); k++) begin
    if (!raw_bits_q[k]) begin
      level = ~level;
    end
    exp_line_q.push_back(line_level(level, flip));
    run = raw_bits_q[k] ? run + 1 : 0;
    if (run == usb_tx_pkg::StuffLimit) begin
      level = ~level;
      exp_line_q.push_back(line_level(level, flip));
      run = 0;
      if (k >= crc_start) begin
        model_crc_stuffed = 1'b1;
      end
    end
  end

  // End of packet
  exp_line_q.push_back(2'b00);
  exp_line_q.push_back(2'b00);
  exp_line_q.push_back(line_level(1'b1, flip));
endfunction

`endif

/* dv/usb_tx_tb.sv */
// Testbench for the USB full-speed packet transmitter.
// Sends random packets, samples dp/dn in the middle of every bit and
// compares them with the reference model, stopping at the first error.

module usb_tx_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ClksPerBit  = usb_tx_pkg::DefaultClksPerBit;
  localparam int ClkPeriodNs = 40;
  // SYNC, PID, 8 bytes, CRC, worst stuffing, EOP and the gap
  localparam int MaxPktBits  = 128;
  localparam int NumPackets  = 32;
  localparam int WatchdogNs  = NumPackets * MaxPktBits * ClksPerBit * ClkPeriodNs * 2;

  logic       clk_i;
  logic       rst_ni;
  logic       link_reset_i;
  logic       cfg_pinflip_i;
  logic       pkt_start_i;
  logic [3:0] pid_i;
  logic       tx_data_avail_i;
  logic [7:0] tx_data_i;
  logic       tx_data_get_o;
  logic       pkt_end_o;
  logic       usb_dp_o;
  logic       usb_dn_o;
  logic       usb_oe_o;

  logic [7:0] payload_mem [0:15];
  int         payload_len;
  int         src_idx;
  bit         src_stop;
  int         end_count;
  int         error_count;

  `include "usb_tx_model.svh"

  usb_fs_tx_top #(
    .ClksPerBit(ClksPerBit)
  ) u_dut (
    .clk_i, .rst_ni, .link_reset_i, .cfg_pinflip_i, .pkt_start_i, .pid_i,
    .tx_data_avail_i, .tx_data_i, .tx_data_get_o, .pkt_end_o,
    .usb_dp_o, .usb_dn_o, .usb_oe_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriodNs / 2) clk_i = ~clk_i;
  end

  // Counts end-of-packet pulses over the whole run
  initial begin
    end_count = 0;
    forever begin
      @(posedge clk_i);
      if (pkt_end_o) begin
        end_count++;
      end
    end
  end

  initial begin
    #(WatchdogNs);
    abort_run("Watchdog expired before all packets were checked");
  end

  ////////////////////////////////
  // Checking
  ////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("Mismatch in %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      abort_run("Stopping at the first error");
    end
  endtask

  // Quiet line means oe low and J for the current pin order
  task automatic check_idle(input string name);
    @(negedge clk_i);
    compare({name, " oe"}, 0, 32'(usb_oe_o));
    compare({name, " line"}, 32'(line_level(1'b1, cfg_pinflip_i)),
            32'({usb_dp_o, usb_dn_o}));
  endtask

  task automatic sample_line(input string name);
    int guard;
    guard = 0;
    @(negedge clk_i);
    while (usb_oe_o !== 1'b1) begin
      guard++;
      if (guard > 4 * ClksPerBit + 4) begin
        abort_run({name, ": usb_oe_o never rose after the start pulse"});
      end
      @(negedge clk_i);
    end
    // Move to the middle of the first bit
    repeat ((ClksPerBit - 1) / 2) @(negedge clk_i);
    for (int k = 0; k < exp_line_q.size(); k++) begin
      if (k > 0) begin
        repeat (ClksPerBit) @(negedge clk_i);
      end
      compare($sformatf("%s bit %0d oe", name, k), 1, 32'(usb_oe_o));
      compare($sformatf("%s bit %0d line", name, k), 32'(exp_line_q[k]),
              32'({usb_dp_o, usb_dn_o}));
    end
    repeat (ClksPerBit) @(negedge clk_i);
    compare({name, " oe after EOP"}, 0, 32'(usb_oe_o));
    compare({name, " line after EOP"}, 32'(line_level(1'b1, cfg_pinflip_i)),
            32'({usb_dp_o, usb_dn_o}));
  endtask

  ////////////////////////////////
  // Stimulus
  ////////////////////////////////

  function automatic logic [3:0] random_pid(input bit data);
    logic [1:0] code;
    logic [1:0] group;
    code  = 2'($urandom_range(0, 3));
    group = data ? usb_tx_pkg::PidGroupData : 2'($urandom_range(0, 2));
    return {code, group};
  endfunction

  function automatic void fill_payload(input int len, input bit ff_rich);
    payload_len = len;
    for (int i = 0; i < 16; i++) begin
      payload_mem[i] = (ff_rich && $urandom_range(0, 3) != 0) ? 8'hFF : 8'($urandom);
    end
  endfunction

  // Byte source that presents the next byte once the current one is taken
  task automatic serve_source();
    while (!src_stop) begin
      @(posedge clk_i);
      if (tx_data_get_o) begin
        src_idx++;
        tx_data_i       <= payload_mem[src_idx[3:0]];
        tx_data_avail_i <= (src_idx < payload_len);
      end
    end
  endtask

  task automatic start_packet(input logic [3:0] pid);
    src_idx  = 0;
    src_stop = 1'b0;
    @(posedge clk_i);
    pkt_start_i     <= 1'b1;
    pid_i           <= pid;
    tx_data_i       <= payload_mem[0];
    tx_data_avail_i <= (payload_len > 0);
    @(posedge clk_i);
    pkt_start_i <= 1'b0;
  endtask

  task automatic send_packet(input string name, input logic [3:0] pid);
    int ends_before;
    int gets;
    build_expected(pid, cfg_pinflip_i);
    gets = (pid[1:0] == usb_tx_pkg::PidGroupData) ? payload_len : 0;
    check_idle({name, " idle"});
    ends_before = end_count;
    start_packet(pid);
    fork
      serve_source();
      begin
        sample_line(name);
        src_stop = 1'b1;
      end
    join
    compare({name, " data pulls"}, gets, src_idx);
    compare({name, " pkt_end pulses"}, 1, end_count - ends_before);
  endtask

  // Link reset somewhere inside a packet, then a quiet line
  task automatic abort_packet(input string name, input logic [3:0] pid);
    int ends_before;
    int delay;
    check_idle({name, " idle"});
    ends_before = end_count;
    delay = $urandom_range(8, 16 * ClksPerBit);
    start_packet(pid);
    fork
      serve_source();
      begin
        repeat (delay) @(posedge clk_i);
        link_reset_i <= 1'b1;
        @(posedge clk_i);
        link_reset_i <= 1'b0;
        repeat (30 * ClksPerBit) begin
          @(negedge clk_i);
          compare({name, " oe after link reset"}, 0, 32'(usb_oe_o));
          compare({name, " line after link reset"},
                  32'(line_level(1'b1, cfg_pinflip_i)), 32'({usb_dp_o, usb_dn_o}));
        end
        src_stop = 1'b1;
      end
    join
    compare({name, " pkt_end pulses"}, 0, end_count - ends_before);
  endtask

  initial begin
    logic [3:0] pid;
    int         tries;
    void'($urandom(34));
    error_count     = 0;
    src_idx         = 0;
    src_stop        = 1'b1;
    payload_len     = 0;
    rst_ni          = 1'b0;
    link_reset_i    = 1'b0;
    cfg_pinflip_i   = 1'b0;
    pkt_start_i     = 1'b0;
    pid_i           = 4'h0;
    tx_data_avail_i = 1'b0;
    tx_data_i       = 8'h00;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    check_idle("after reset");

    // Tokens and handshakes, bytes offered but never pulled
    for (int n = 0; n < 4; n++) begin
      fill_payload(8, 1'b0);
      send_packet($sformatf("no-data packet %0d", n), random_pid(1'b0));
    end

    for (int n = 0; n < 12; n++) begin
      fill_payload($urandom_range(0, 8), 1'b0);
      send_packet($sformatf("data packet %0d", n), random_pid(1'b1));
    end

    // Search for payloads whose CRC also needs a stuffed bit
    for (int n = 0; n < 4; n++) begin
      pid   = random_pid(1'b1);
      tries = 0;
      do begin
        fill_payload($urandom_range(1, 8), 1'b1);
        build_expected(pid, cfg_pinflip_i);
        tries++;
      end while (!model_crc_stuffed && tries < 200);
      send_packet($sformatf("stuffing packet %0d", n), pid);
    end

    @(posedge clk_i);
    cfg_pinflip_i <= 1'b1;
    @(posedge clk_i);
    for (int n = 0; n < 6; n++) begin
      fill_payload($urandom_range(0, 8), 1'b0);
      send_packet($sformatf("flipped packet %0d", n), random_pid(1'($urandom_range(0, 1))));
    end
    @(posedge clk_i);
    cfg_pinflip_i <= 1'b0;
    @(posedge clk_i);

    for (int n = 0; n < 3; n++) begin
      fill_payload($urandom_range(0, 8), 1'b0);
      abort_packet($sformatf("aborted packet %0d", n), random_pid(1'($urandom_range(0, 1))));
      fill_payload($urandom_range(0, 8), 1'b0);
      send_packet($sformatf("packet after abort %0d", n), random_pid(1'b1));
    end

    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+dv
logic/usb_tx_pkg.sv
logic/usb_bit_timer.sv
logic/usb_tx_sequencer.sv
logic/usb_tx_serializer.sv
logic/usb_crc16.sv
logic/usb_line_driver.sv
logic/usb_fs_tx_top.sv
dv/usb_tx_tb.sv

/* Makefile */
# Verilator flow for the USB full-speed transmitter
TOP := usb_tx_tb
OBJ := obj_dir
RTL := $(shell grep '^logic/' project.f)

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -j 0 -f project.f --top-module $(TOP) -Mdir $(OBJ)

# The run passes only if the log holds the pass line
run: build
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

lint:
	verilator --lint-only -Wall $(RTL) --top-module usb_fs_tx_top

clean:
	rm -rf $(OBJ) sim.log
